// ==== icache_geom_pkg.sv ====
package icache_geom_pkg;

    // two ways of 64 sets, 16-word blocks
    localparam int way_num     = 2;
    localparam int block_words = 16;
    localparam int set_num     = 64;
    localparam int index_w     = 6;
    localparam int tag_w       = 20;

    // data RAM holds one aligned instruction pair per word
    localparam int pair_w      = 64;
    localparam int pair_depth  = 512;
    localparam int pair_addr_w = $clog2(pair_depth);

    typedef struct packed {
        logic             valid;
        logic [tag_w-1:0] tag;
    } tag_entry_t;

    // one physical address, read as a fetch or as a maintenance operand
    typedef union packed {
        struct packed {
            logic [tag_w-1:0]   tag;
            logic [index_w-1:0] index;
            logic [2:0]         pair;
            logic [2:0]         offset;
        } fetch;
        struct packed {
            logic [30:0] upper;
            // way select for the single-way invalidate
            logic        way_sel;
        } cacop;
    } icache_addr_u;

endpackage

// ==== icache_bus_pkg.sv ====
package icache_bus_pkg;

    // every refill moves one whole block
    localparam int burst_beats = icache_geom_pkg::block_words;
    localparam int beat_cnt_w  = 5;

    // index-invalidate codes from commit
    localparam logic [1:0] cacop_inv_way0 = 2'd0;
    localparam logic [1:0] cacop_inv_way1 = 2'd1;
    localparam logic [1:0] cacop_inv_both = 2'd2;

    typedef enum logic [1:0] {
        st_idle,
        st_miss_req,
        st_miss_beats,
        st_hold
    } refill_state_e;

endpackage

// ==== icache_dpsram.sv ====
module icache_dpsram #(
    parameter int data_w = 32,
    parameter int depth  = 64
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [$clog2(depth)-1:0] rd_addr_i,
    output logic [data_w-1:0]        rd_data_o,
    input  logic                     wr_en_i,
    input  logic [$clog2(depth)-1:0] wr_addr_i,
    input  logic [data_w-1:0]        wr_data_i,
    output logic [data_w-1:0]        wr_rd_data_o
);

    logic [data_w-1:0] mem [depth];

    // read-only port, old data on a same-row write
    always_ff @(posedge clk) begin
        rd_data_o <= mem[rd_addr_i];
    end

    // read/write port returns what it writes
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
            wr_rd_data_o   <= wr_data_i;
        end else begin
            wr_rd_data_o <= mem[wr_addr_i];
        end
    end

    a_wr_addr_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_en_i |-> !$isunknown(wr_addr_i)
    );

endmodule

// ==== icache_tag_array.sv ====
module icache_tag_array (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [icache_geom_pkg::index_w-1:0] lookup_index_i,
    input  logic [icache_geom_pkg::tag_w-1:0]   lookup_tag_i,
    input  logic [icache_geom_pkg::index_w-1:0] wr_index_i,
    input  logic [icache_geom_pkg::way_num-1:0] wr_way_i,
    input  icache_geom_pkg::tag_entry_t         wr_entry_i,
    output logic [icache_geom_pkg::way_num-1:0] tag_hit_o
);
    import icache_geom_pkg::*;

    logic             conflict_q;
    logic [tag_w-1:0] lookup_tag_q;

    // write row equals read row, take the write port readback
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            conflict_q <= 1'b0;
        end else begin
            conflict_q <= (lookup_index_i == wr_index_i);
        end
    end

    always_ff @(posedge clk) begin
        lookup_tag_q <= lookup_tag_i;
    end

    for (genvar w = 0; w < way_num; w++) begin : g_way
        tag_entry_t rd_entry;
        tag_entry_t wb_entry;
        tag_entry_t cur_entry;

        icache_dpsram #(
            .data_w($bits(tag_entry_t)),
            .depth (set_num)
        ) i_tag_ram (
            .clk         (clk),
            .rst_n       (rst_n),
            .rd_addr_i   (lookup_index_i),
            .rd_data_o   (rd_entry),
            .wr_en_i     (wr_way_i[w]),
            .wr_addr_i   (wr_index_i),
            .wr_data_i   (wr_entry_i),
            .wr_rd_data_o(wb_entry)
        );

        assign cur_entry    = conflict_q ? wb_entry : rd_entry;
        assign tag_hit_o[w] = cur_entry.valid && (cur_entry.tag == lookup_tag_q);
    end

    // a block is only ever resident in one way
    a_hit_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(tag_hit_o)
    );

endmodule

// ==== icache_data_array.sv ====
module icache_data_array (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic [icache_geom_pkg::pair_addr_w-1:0] lookup_pair_addr_i,
    input  logic [icache_geom_pkg::pair_addr_w-1:0] wr_pair_addr_i,
    input  logic [icache_geom_pkg::way_num-1:0]     wr_way_i,
    input  logic [icache_geom_pkg::pair_w-1:0]      wr_pair_i,
    input  logic [icache_geom_pkg::way_num-1:0]     tag_hit_i,
    output logic [icache_geom_pkg::pair_w-1:0]      pair_o
);
    import icache_geom_pkg::*;

    logic              conflict_q;
    logic [pair_w-1:0] way_pair [way_num];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            conflict_q <= 1'b0;
        end else begin
            conflict_q <= (lookup_pair_addr_i == wr_pair_addr_i);
        end
    end

    for (genvar w = 0; w < way_num; w++) begin : g_way
        logic [pair_w-1:0] rd_pair;
        logic [pair_w-1:0] wb_pair;

        icache_dpsram #(
            .data_w(pair_w),
            .depth (pair_depth)
        ) i_data_ram (
            .clk         (clk),
            .rst_n       (rst_n),
            .rd_addr_i   (lookup_pair_addr_i),
            .rd_data_o   (rd_pair),
            .wr_en_i     (wr_way_i[w]),
            .wr_addr_i   (wr_pair_addr_i),
            .wr_data_i   (wr_pair_i),
            .wr_rd_data_o(wb_pair)
        );

        assign way_pair[w] = conflict_q ? wb_pair : rd_pair;
    end

    // hit vector is one-hot, so an OR of the masked ways selects
    always_comb begin
        pair_o = '0;
        for (int w = 0; w < way_num; w++) begin
            if (tag_hit_i[w]) begin
                pair_o = pair_o | way_pair[w];
            end
        end
    end

endmodule

// ==== icache_refill_fsm.sv ====
module icache_refill_fsm (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    flush_i,
    input  logic                                    fetch_valid_i,
    input  logic [31:0]                             fetch_pc_i,
    output logic                                    fetch_ready_o,
    output logic                                    inst_valid_o,
    output logic [icache_geom_pkg::pair_w-1:0]      inst_pair_o,
    output logic [31:0]                             inst_pc_o,
    input  logic                                    inst_ready_i,
    output logic                                    mem_req_o,
    output logic [31:0]                             mem_addr_o,
    input  logic                                    mem_ack_i,
    input  logic                                    mem_beat_valid_i,
    input  logic [31:0]                             mem_beat_i,
    input  logic                                    cacop_valid_i,
    input  logic [1:0]                              cacop_op_i,
    input  logic [31:0]                             cacop_addr_i,
    output logic                                    cacop_ready_o,
    output icache_geom_pkg::icache_addr_u           lookup_addr_o,
    input  logic [icache_geom_pkg::way_num-1:0]     tag_hit_i,
    input  logic [icache_geom_pkg::pair_w-1:0]      hit_pair_i,
    output logic [icache_geom_pkg::index_w-1:0]     tag_wr_index_o,
    output logic [icache_geom_pkg::way_num-1:0]     tag_wr_way_o,
    output icache_geom_pkg::tag_entry_t             tag_wr_entry_o,
    output logic [icache_geom_pkg::pair_addr_w-1:0] data_wr_addr_o,
    output logic [icache_geom_pkg::way_num-1:0]     data_wr_way_o,
    output logic [icache_geom_pkg::pair_w-1:0]      data_wr_pair_o
);
    import icache_geom_pkg::*;
    import icache_bus_pkg::*;

    refill_state_e          state_q;
    logic                   req_valid_q;
    icache_addr_u           req_q;
    icache_addr_u           cacop_a;
    logic [index_w:0]       sweep_cnt_q;
    logic [set_num-1:0]     victim_q;
    logic [beat_cnt_w-1:0]  beat_cnt_q;
    logic [31:0]            half_q;
    logic [pair_w-1:0]      out_pair_q;
    logic                   wr_pend_q;
    logic                   wr_last_q;
    logic [pair_addr_w-1:0] wr_addr_q;
    logic [way_num-1:0]     wr_way_q;
    logic [pair_w-1:0]      wr_pair_q;
    logic [way_num-1:0]     cacop_way;
    logic                   sweep_done;
    logic                   idle;
    logic                   hit;
    logic                   cacop_take;
    logic                   fetch_take;
    logic                   miss_start;
    logic                   beat_take;
    logic                   last_beat;

    // tag sweep after reset keeps the cache closed
    assign sweep_done = sweep_cnt_q[index_w];
    assign idle       = (state_q == st_idle) && sweep_done;
    assign hit        = |tag_hit_i;
    assign cacop_a    = cacop_addr_i;

    // maintenance wins over fetch in the same cycle
    assign cacop_ready_o = idle && !req_valid_q && !wr_pend_q;
    assign cacop_take    = cacop_valid_i && cacop_ready_o;
    assign fetch_ready_o = idle && !flush_i && !cacop_take &&
                           (!req_valid_q || (hit && inst_ready_i));
    assign fetch_take    = fetch_valid_i && fetch_ready_o;

    assign miss_start = idle && req_valid_q && !hit && !flush_i;
    assign beat_take  = (state_q == st_miss_beats) && mem_beat_valid_i;
    assign last_beat  = beat_take && (beat_cnt_q == beat_cnt_w'(burst_beats - 1));

    assign lookup_addr_o = fetch_take ? {fetch_pc_i[31:3], 3'b000} : req_q;

    assign inst_valid_o = (state_q == st_hold) || (idle && req_valid_q && hit);
    assign inst_pair_o  = (state_q == st_hold) ? out_pair_q : hit_pair_i;
    assign inst_pc_o    = req_q;

    assign mem_req_o  = (state_q == st_miss_req) || miss_start;
    assign mem_addr_o = {req_q.fetch.tag, req_q.fetch.index, 6'd0};

    always_comb begin
        case (cacop_op_i)
            cacop_inv_way0, cacop_inv_way1: cacop_way = way_num'(1) << cacop_a.cacop.way_sel;
            cacop_inv_both:                 cacop_way = '1;
            default:                        cacop_way = '0;
        endcase
    end

    // tag port: sweep, then maintenance, then refill tag
    always_comb begin
        tag_wr_index_o = wr_addr_q[pair_addr_w-1 -: index_w];
        tag_wr_way_o   = wr_last_q ? wr_way_q : '0;
        tag_wr_entry_o = '{valid: 1'b1, tag: req_q.fetch.tag};
        if (!sweep_done) begin
            tag_wr_index_o = sweep_cnt_q[index_w-1:0];
            tag_wr_way_o   = '1;
            tag_wr_entry_o = '0;
        end else if (cacop_take) begin
            tag_wr_index_o = cacop_a.fetch.index;
            tag_wr_way_o   = cacop_way;
            tag_wr_entry_o = '0;
        end
    end

    assign data_wr_addr_o = wr_addr_q;
    assign data_wr_way_o  = wr_pend_q ? wr_way_q : '0;
    assign data_wr_pair_o = wr_pair_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q     <= st_idle;
            req_valid_q <= 1'b0;
            sweep_cnt_q <= '0;
            victim_q    <= '0;
            beat_cnt_q  <= '0;
            wr_pend_q   <= 1'b0;
            wr_last_q   <= 1'b0;
        end else begin
            // a pair is written the cycle after its odd beat
            wr_pend_q <= beat_take && beat_cnt_q[0];
            wr_last_q <= last_beat;
            if (!sweep_done) begin
                sweep_cnt_q <= sweep_cnt_q + 1'b1;
            end
            if (beat_take) begin
                beat_cnt_q <= last_beat ? '0 : beat_cnt_q + 1'b1;
            end
            if (last_beat) begin
                victim_q[req_q.fetch.index] <= !victim_q[req_q.fetch.index];
            end
            if (flush_i) begin
                req_valid_q <= 1'b0;
            end else if (fetch_take) begin
                req_valid_q <= 1'b1;
            end else if (inst_valid_o && inst_ready_i) begin
                req_valid_q <= 1'b0;
            end
            case (state_q)
                st_idle: begin
                    if (miss_start) begin
                        state_q <= mem_ack_i ? st_miss_beats : st_miss_req;
                    end else if (inst_valid_o && !inst_ready_i && !flush_i) begin
                        state_q <= st_hold;
                    end
                end
                st_miss_req: begin
                    if (mem_ack_i) begin
                        state_q <= st_miss_beats;
                    end
                end
                st_miss_beats: begin
                    // a flushed request finishes the block without output
                    if (last_beat) begin
                        state_q <= (req_valid_q && !flush_i) ? st_hold : st_idle;
                    end
                end
                default: begin
                    if (inst_ready_i || flush_i) begin
                        state_q <= st_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_take) begin
            req_q <= {fetch_pc_i[31:3], 3'b000};
        end
        if (beat_take) begin
            if (!beat_cnt_q[0]) begin
                half_q <= mem_beat_i;
            end
            wr_addr_q <= {req_q.fetch.index, beat_cnt_q[3:1]};
            wr_way_q  <= way_num'(1) << victim_q[req_q.fetch.index];
            wr_pair_q <= {mem_beat_i, half_q};
        end
        // grab the requested pair as it streams past
        if (beat_take && beat_cnt_q[0] && (beat_cnt_q[3:1] == req_q.fetch.pair)) begin
            out_pair_q <= {mem_beat_i, half_q};
        end else if (state_q == st_idle && inst_valid_o && !inst_ready_i) begin
            out_pair_q <= hit_pair_i;
        end
    end

    a_req_until_ack: assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_req_o && !mem_ack_i |=> mem_req_o
    );

endmodule

// ==== icache_top.sv ====
module icache_top (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               flush_i,
    input  logic                               fetch_valid_i,
    input  logic [31:0]                        fetch_pc_i,
    output logic                               fetch_ready_o,
    output logic                               inst_valid_o,
    output logic [icache_geom_pkg::pair_w-1:0] inst_pair_o,
    output logic [31:0]                        inst_pc_o,
    input  logic                               inst_ready_i,
    output logic                               mem_req_o,
    output logic [31:0]                        mem_addr_o,
    input  logic                               mem_ack_i,
    input  logic                               mem_beat_valid_i,
    input  logic [31:0]                        mem_beat_i,
    input  logic                               cacop_valid_i,
    input  logic [1:0]                         cacop_op_i,
    input  logic [31:0]                        cacop_addr_i,
    output logic                               cacop_ready_o
);
    import icache_geom_pkg::*;

    icache_addr_u           lookup_addr;
    logic [way_num-1:0]     tag_hit;
    logic [pair_w-1:0]      hit_pair;
    logic [index_w-1:0]     tag_wr_index;
    logic [way_num-1:0]     tag_wr_way;
    tag_entry_t             tag_wr_entry;
    logic [pair_addr_w-1:0] data_wr_addr;
    logic [way_num-1:0]     data_wr_way;
    logic [pair_w-1:0]      data_wr_pair;

    icache_refill_fsm i_refill_fsm (
        .clk             (clk),
        .rst_n           (rst_n),
        .flush_i         (flush_i),
        .fetch_valid_i   (fetch_valid_i),
        .fetch_pc_i      (fetch_pc_i),
        .fetch_ready_o   (fetch_ready_o),
        .inst_valid_o    (inst_valid_o),
        .inst_pair_o     (inst_pair_o),
        .inst_pc_o       (inst_pc_o),
        .inst_ready_i    (inst_ready_i),
        .mem_req_o       (mem_req_o),
        .mem_addr_o      (mem_addr_o),
        .mem_ack_i       (mem_ack_i),
        .mem_beat_valid_i(mem_beat_valid_i),
        .mem_beat_i      (mem_beat_i),
        .cacop_valid_i   (cacop_valid_i),
        .cacop_op_i      (cacop_op_i),
        .cacop_addr_i    (cacop_addr_i),
        .cacop_ready_o   (cacop_ready_o),
        .lookup_addr_o   (lookup_addr),
        .tag_hit_i       (tag_hit),
        .hit_pair_i      (hit_pair),
        .tag_wr_index_o  (tag_wr_index),
        .tag_wr_way_o    (tag_wr_way),
        .tag_wr_entry_o  (tag_wr_entry),
        .data_wr_addr_o  (data_wr_addr),
        .data_wr_way_o   (data_wr_way),
        .data_wr_pair_o  (data_wr_pair)
    );

    icache_tag_array i_tag_array (
        .clk           (clk),
        .rst_n         (rst_n),
        .lookup_index_i(lookup_addr.fetch.index),
        .lookup_tag_i  (lookup_addr.fetch.tag),
        .wr_index_i    (tag_wr_index),
        .wr_way_i      (tag_wr_way),
        .wr_entry_i    (tag_wr_entry),
        .tag_hit_o     (tag_hit)
    );

    // pair address is index plus pair-in-block
    icache_data_array i_data_array (
        .clk               (clk),
        .rst_n             (rst_n),
        .lookup_pair_addr_i({lookup_addr.fetch.index, lookup_addr.fetch.pair}),
        .wr_pair_addr_i    (data_wr_addr),
        .wr_way_i          (data_wr_way),
        .wr_pair_i         (data_wr_pair),
        .tag_hit_i         (tag_hit),
        .pair_o            (hit_pair)
    );

endmodule

// ==== tb_icache_mem.sv ====
module tb_icache_mem (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        mem_req_i,
    input  logic [31:0] mem_addr_i,
    output logic        mem_ack_o,
    output logic        mem_beat_valid_o,
    output logic [31:0] mem_beat_o,
    output int          req_count_o
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] word_key  = 32'hC0DE0000;
    localparam int          burst_len = 16;

    logic [31:0] rand_state;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // requests are sampled on the falling edge, responses driven on the rising edge
    initial begin
        logic [31:0] base;
        int          wait_n;
        mem_ack_o        = 1'b0;
        mem_beat_valid_o = 1'b0;
        mem_beat_o       = '0;
        req_count_o      = 0;
        rand_state       = 32'h7503;
        forever begin
            @(negedge clk);
            if (rst_n === 1'b1 && mem_req_i === 1'b1) begin
                base        = mem_addr_i;
                req_count_o = req_count_o + 1;
                // ack after 0 to 3 idle cycles
                rand_state  = lcg_next(rand_state);
                wait_n      = int'(rand_state[17:16]);
                repeat (wait_n) @(posedge clk);
                @(posedge clk);
                mem_ack_o <= 1'b1;
                @(posedge clk);
                mem_ack_o <= 1'b0;
                for (int i = 0; i < burst_len; i++) begin
                    rand_state = lcg_next(rand_state);
                    wait_n     = int'(rand_state[31:16] % 3);
                    if (wait_n != 0) begin
                        mem_beat_valid_o <= 1'b0;
                        repeat (wait_n) @(posedge clk);
                    end
                    mem_beat_valid_o <= 1'b1;
                    mem_beat_o       <= (base + 32'(4 * i)) ^ word_key;
                    @(posedge clk);
                end
                mem_beat_valid_o <= 1'b0;
            end
        end
    end

endmodule

// ==== tb_icache.sv ====
module tb_icache;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          num_tests = 5;
    localparam logic [31:0] mem_key   = 32'hC0DE0000;

    logic        clk;
    logic        rst_n;
    logic        flush_i;
    logic        fetch_valid_i;
    logic [31:0] fetch_pc_i;
    logic        fetch_ready_o;
    logic        inst_valid_o;
    logic [63:0] inst_pair_o;
    logic [31:0] inst_pc_o;
    logic        inst_ready_i;
    logic        mem_req_o;
    logic [31:0] mem_addr_o;
    logic        mem_ack_i;
    logic        mem_beat_valid_i;
    logic [31:0] mem_beat_i;
    logic        cacop_valid_i;
    logic [1:0]  cacop_op_i;
    logic [31:0] cacop_addr_i;
    logic        cacop_ready_o;
    int          req_count;

    string       test_name;
    int          error_count;
    int          check_count;
    int          tests_run;
    int          errors_at_start;
    logic [31:0] rand_state;
    logic [31:0] cold_pc [4];

    icache_top i_icache_top (.*);

    tb_icache_mem i_mem (
        .clk             (clk),
        .rst_n           (rst_n),
        .mem_req_i       (mem_req_o),
        .mem_addr_i      (mem_addr_o),
        .mem_ack_o       (mem_ack_i),
        .mem_beat_valid_o(mem_beat_valid_i),
        .mem_beat_o      (mem_beat_i),
        .req_count_o     (req_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // each memory word holds its byte address xor the key
    // the low word of a pair is the one at the lower address
    function automatic logic [63:0] expected_pair(input logic [31:0] pc);
        logic [31:0] base;
        base = {pc[31:3], 3'b000};
        return {(base + 32'd4) ^ mem_key, base ^ mem_key};
    endfunction

    task automatic check_value(input string what, input logic [63:0] exp,
                               input logic [63:0] act);
        check_count++;
        assert (act === exp) else begin
            $display("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act);
            error_count++;
        end
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = error_count;
    endtask

    task automatic report_test();
        tests_run++;
        if (error_count == errors_at_start) begin
            $display("test %s: passed", test_name);
        end else begin
            $display("test %s: failed, %0d errors", test_name, error_count - errors_at_start);
        end
    endtask

    // returns on the accepting edge
    task automatic issue_fetch(input logic [31:0] pc);
        @(posedge clk);
        fetch_valid_i <= 1'b1;
        fetch_pc_i    <= pc;
        do @(negedge clk); while (!fetch_ready_o);
        @(posedge clk);
        fetch_valid_i <= 1'b0;
    endtask

    task automatic wait_pair(output logic [63:0] pair, output int lat);
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!inst_valid_o);
        pair = inst_pair_o;
    endtask

    task automatic fetch_and_check(input logic [31:0] pc, input int new_reqs);
        logic [63:0] pair;
        int          lat;
        int          reqs_before;
        reqs_before = req_count;
        issue_fetch(pc);
        if (new_reqs != 0) begin
            @(negedge clk);
            check_value("miss request", 1, mem_req_o);
            check_value("miss address", {pc[31:6], 6'd0}, mem_addr_o);
        end
        wait_pair(pair, lat);
        check_value("pair", expected_pair(pc), pair);
        check_value("pc", pc, inst_pc_o);
        check_value("requests", new_reqs, req_count - reqs_before);
        if (new_reqs == 0) begin
            check_value("hit latency", 1, lat);
        end
    endtask

    task automatic stalled_fetch(input logic [31:0] pc);
        logic [63:0] first_pair;
        int          lat;
        @(posedge clk);
        inst_ready_i <= 1'b0;
        issue_fetch(pc);
        wait_pair(first_pair, lat);
        check_value("stall pair", expected_pair(pc), first_pair);
        repeat (4) begin
            @(negedge clk);
            check_value("stall valid", 1, inst_valid_o);
            check_value("stall pair held", first_pair, inst_pair_o);
            check_value("stall pc held", pc, inst_pc_o);
            check_value("stall fetch ready", 0, fetch_ready_o);
            check_value("stall cacop ready", 0, cacop_ready_o);
        end
        @(posedge clk);
        inst_ready_i <= 1'b1;
        // pair is taken on this edge
        @(posedge clk);
    endtask

    task automatic issue_cacop(input logic [1:0] op, input logic [31:0] addr);
        @(posedge clk);
        cacop_valid_i <= 1'b1;
        cacop_op_i    <= op;
        cacop_addr_i  <= addr;
        do @(negedge clk); while (!cacop_ready_o);
        check_value("fetch ready during cacop", 0, fetch_ready_o);
        @(posedge clk);
        cacop_valid_i <= 1'b0;
    endtask

    // one random block per index 0..3
    task automatic cold_miss_fill();
        logic [31:0] r;
        start_test("cold_miss");
        for (int i = 0; i < 4; i++) begin
            rand_state = lcg_next(rand_state);
            r          = rand_state;
            cold_pc[i] = {4'h1, r[27:12], 6'(i), r[5:3], 3'b000};
            fetch_and_check(cold_pc[i], 1);
        end
        report_test();
    endtask

    task automatic hit_in_block();
        start_test("hit");
        fetch_and_check(cold_pc[0] ^ 32'h0000_0018, 0);
        fetch_and_check(cold_pc[0], 0);
        fetch_and_check(cold_pc[1], 0);
        report_test();
    endtask

    task automatic way_replacement();
        logic [31:0] blk_a;
        logic [31:0] blk_b;
        logic [31:0] blk_c;
        start_test("replacement");
        blk_a = {20'h80001, 6'h2A, 3'd1, 3'b000};
        blk_b = {20'h80002, 6'h2A, 3'd4, 3'b000};
        blk_c = {20'h80003, 6'h2A, 3'd7, 3'b000};
        // a fills way 0 and b fills way 1 before c evicts a
        fetch_and_check(blk_a, 1);
        fetch_and_check(blk_b, 1);
        fetch_and_check(blk_c, 1);
        fetch_and_check(blk_b, 0);
        // victim now points at way 1 so a replaces b
        fetch_and_check(blk_a, 1);
        fetch_and_check(blk_c, 0);
        report_test();
    endtask

    task automatic index_invalidate();
        logic [31:0] blk_d;
        logic [31:0] blk_e;
        logic [31:0] maint;
        start_test("maintenance");
        blk_d = {20'h90001, 6'h15, 3'd2, 3'b000};
        blk_e = {20'h90002, 6'h15, 3'd5, 3'b000};
        maint = {20'h0, 6'h15, 6'h00};
        fetch_and_check(blk_d, 1);
        fetch_and_check(blk_e, 1);
        // d sits in way 0 and address bit 0 selects it
        issue_cacop(2'd0, maint);
        fetch_and_check(blk_d, 1);
        fetch_and_check(blk_e, 0);
        issue_cacop(2'd2, maint);
        fetch_and_check(blk_e, 1);
        fetch_and_check(blk_d, 1);
        report_test();
    endtask

    task automatic stall_and_flush();
        logic [31:0] blk_f;
        logic [31:0] blk_g;
        int          reqs_before;
        start_test("stall_flush");
        blk_f = {20'hA0001, 6'h33, 3'd3, 3'b000};
        blk_g = {20'hA0002, 6'h34, 3'd6, 3'b000};
        stalled_fetch(cold_pc[0] ^ 32'h0000_0008);
        stalled_fetch(blk_f);
        reqs_before = req_count;
        issue_fetch(blk_g);
        @(negedge clk);
        check_value("refill started", 1, mem_req_o);
        @(posedge clk);
        flush_i <= 1'b1;
        @(posedge clk);
        flush_i <= 1'b0;
        // refill runs to the end with nothing on the output
        do begin
            @(negedge clk);
            check_value("valid after flush", 0, inst_valid_o);
        end while (!fetch_ready_o);
        check_value("flushed requests", 1, req_count - reqs_before);
        fetch_and_check(blk_g, 0);
        report_test();
    endtask

    initial begin
        #(num_tests * 2000);
        $display("timeout: the tests did not finish within %0d ns", num_tests * 2000);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        rst_n         = 1'b0;
        flush_i       = 1'b0;
        fetch_valid_i = 1'b0;
        fetch_pc_i    = '0;
        inst_ready_i  = 1'b1;
        cacop_valid_i = 1'b0;
        cacop_op_i    = '0;
        cacop_addr_i  = '0;
        error_count   = 0;
        check_count   = 0;
        tests_run     = 0;
        rand_state    = 32'h7503;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        // tag sweep keeps the cache closed for a while
        do @(negedge clk); while (!fetch_ready_o);
        cold_miss_fill();
        hit_in_block();
        way_replacement();
        index_invalidate();
        stall_and_flush();
        $display("tests %0d, checks %0d, errors %0d", tests_run, check_count, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== project.f ====
icache_geom_pkg.sv
icache_bus_pkg.sv
icache_dpsram.sv
icache_tag_array.sv
icache_data_array.sv
icache_refill_fsm.sv
icache_top.sv
tb_icache_mem.sv
tb_icache.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_icache
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TEST OK

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)

test: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
